/* src/decode_pkg.sv */
`default_nettype none

package decode_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths and flow control
	//////////////////////////////////////////////////////////////////////

	localparam int unsigned byte_w = 8;
	localparam int unsigned pc_w = 16;

	// records the execute stage can buffer
	localparam int unsigned decode_credits = 2;
	localparam int unsigned credit_w = $clog2(decode_credits + 1);

	//////////////////////////////////////////////////////////////////////
	// encodings
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		am_none  = 4'd0,
		am_accum = 4'd1,
		am_imm   = 4'd2,
		am_abs   = 4'd3,
		am_zp    = 4'd4,
		am_zpx   = 4'd5,
		am_absx  = 4'd6,
		am_impl  = 4'd7,
		am_rel   = 4'd8,
		am_indx  = 4'd9,
		am_indy  = 4'd10,
		am_ind   = 4'd11,
		am_zpy   = 4'd12,
		am_absy  = 4'd13
	} addr_mode_e;

	// value is the byte count
	typedef enum logic [1:0] {
		sz_one   = 2'd1,
		sz_two   = 2'd2,
		sz_three = 2'd3
	} instr_size_e;

	typedef enum logic [1:0] {
		st_opcode = 2'd0,
		st_lo     = 2'd1,
		st_hi     = 2'd2,
		st_hold   = 2'd3
	} collect_state_e;

	//////////////////////////////////////////////////////////////////////
	// records
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [byte_w-1:0] data;
		logic [pc_w-1:0]   pc;
	} fetch_byte_t;

	typedef struct packed {
		instr_size_e size;
		addr_mode_e  mode;
		logic        illegal;
	} opcode_info_t;

	// pc of the opcode byte, missing operands are zero
	typedef struct packed {
		logic [pc_w-1:0]   pc;
		addr_mode_e        mode;
		instr_size_e       size;
		logic              illegal;
		logic [byte_w-1:0] operand_lo;
		logic [byte_w-1:0] operand_hi;
	} decoded_instr_t;

endpackage

`default_nettype wire

/* src/opcode_table.sv */
`timescale 1ns/10ps
`default_nettype none

module opcode_table (
	input  wire logic [decode_pkg::byte_w-1:0] opcode,
	output decode_pkg::opcode_info_t           info
);

	logic [3:0] row;
	logic [3:0] col;
	logic legal;
	decode_pkg::instr_size_e size;
	decode_pkg::addr_mode_e mode;

	assign row = opcode[7:4];
	assign col = opcode[3:0];

	// column first, odd rows are mostly the indexed forms
	always_comb begin
		legal = 1'b1;
		size = decode_pkg::sz_one;
		mode = decode_pkg::am_none;
		case (col)
			4'h0: begin
				if (row[0]) begin
					size = decode_pkg::sz_two;
					mode = decode_pkg::am_rel;
				end else if (row == 4'h2) begin
					size = decode_pkg::sz_three;
					mode = decode_pkg::am_abs;
				end else if (row == 4'h8) begin
					legal = 1'b0;
				end else if (row[3]) begin
					size = decode_pkg::sz_two;
					mode = decode_pkg::am_imm;
				end else begin
					mode = decode_pkg::am_impl;
				end
			end
			4'h1: begin
				size = decode_pkg::sz_two;
				mode = row[0] ? decode_pkg::am_indy : decode_pkg::am_indx;
			end
			4'h2: begin
				legal = (row == 4'ha);
				size = decode_pkg::sz_two;
				mode = decode_pkg::am_imm;
			end
			4'h4: begin
				size = decode_pkg::sz_two;
				case (row)
					4'h2, 4'h8, 4'ha, 4'hc, 4'he: mode = decode_pkg::am_zp;
					4'h9, 4'hb: mode = decode_pkg::am_zpx;
					default: legal = 1'b0;
				endcase
			end
			4'h5: begin
				size = decode_pkg::sz_two;
				mode = row[0] ? decode_pkg::am_zpx : decode_pkg::am_zp;
			end
			4'h6: begin
				size = decode_pkg::sz_two;
				if (row == 4'h9 || row == 4'hb) begin
					mode = decode_pkg::am_zpy;
				end else begin
					mode = row[0] ? decode_pkg::am_zpx : decode_pkg::am_zp;
				end
			end
			4'h8: mode = decode_pkg::am_impl;
			4'h9: begin
				if (row[0]) begin
					size = decode_pkg::sz_three;
					mode = decode_pkg::am_absy;
				end else begin
					legal = (row != 4'h8);
					size = decode_pkg::sz_two;
					mode = decode_pkg::am_imm;
				end
			end
			4'ha: begin
				// shifts on the accumulator, then register transfers
				case (row)
					4'h0, 4'h2, 4'h4, 4'h6: mode = decode_pkg::am_accum;
					4'h8, 4'h9, 4'ha, 4'hb, 4'hc, 4'he: mode = decode_pkg::am_impl;
					default: legal = 1'b0;
				endcase
			end
			4'hc: begin
				size = decode_pkg::sz_three;
				case (row)
					4'h2, 4'h4, 4'h8, 4'ha, 4'hc, 4'he: mode = decode_pkg::am_abs;
					4'h6: mode = decode_pkg::am_ind;
					4'hb: mode = decode_pkg::am_absx;
					default: legal = 1'b0;
				endcase
			end
			4'hd: begin
				size = decode_pkg::sz_three;
				mode = row[0] ? decode_pkg::am_absx : decode_pkg::am_abs;
			end
			4'he: begin
				legal = (row != 4'h9);
				size = decode_pkg::sz_three;
				if (row == 4'hb) begin
					mode = decode_pkg::am_absy;
				end else begin
					mode = row[0] ? decode_pkg::am_absx : decode_pkg::am_abs;
				end
			end
			// columns 3, 7, b and f
			default: legal = 1'b0;
		endcase
	end

	always_comb begin
		info.size = size;
		info.mode = mode;
		info.illegal = ~legal;
		if (!legal) begin
			info.size = decode_pkg::sz_one;
			info.mode = decode_pkg::am_none;
		end
	end

endmodule

`default_nettype wire

/* src/operand_collector.sv */
`timescale 1ns/10ps
`default_nettype none

module operand_collector (
	input  wire logic                     clk,
	input  wire logic                     rst_n,
	input  wire logic                     in_valid,
	input  wire decode_pkg::fetch_byte_t  in_byte,
	output logic                          in_ready,
	output logic                          rec_valid,
	output decode_pkg::decoded_instr_t    rec,
	input  wire logic                     rec_take
);

	decode_pkg::collect_state_e state;
	decode_pkg::opcode_info_t op_info;
	logic accept;

	opcode_table i_opcode_table (
		.opcode (in_byte.data),
		.info   (op_info)
	);

	assign accept = in_valid && in_ready;

	// stall fetch while a finished record waits for the gate
	assign in_ready = (state != decode_pkg::st_hold);
	assign rec_valid = (state == decode_pkg::st_hold);

	//////////////////////////////////////////////////////////////////////
	// byte sequencing
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= decode_pkg::st_opcode;
		end else begin
			case (state)
				decode_pkg::st_opcode: begin
					if (accept) begin
						if (op_info.size == decode_pkg::sz_one) begin
							state <= decode_pkg::st_hold;
						end else begin
							state <= decode_pkg::st_lo;
						end
					end
				end
				decode_pkg::st_lo: begin
					if (accept) begin
						if (rec.size == decode_pkg::sz_three) begin
							state <= decode_pkg::st_hi;
						end else begin
							state <= decode_pkg::st_hold;
						end
					end
				end
				decode_pkg::st_hi: begin
					if (accept) begin
						state <= decode_pkg::st_hold;
					end
				end
				default: begin
					if (rec_take) begin
						state <= decode_pkg::st_opcode;
					end
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// record assembly
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (accept) begin
			case (state)
				decode_pkg::st_opcode: begin
					rec.pc <= in_byte.pc;
					rec.mode <= op_info.mode;
					rec.size <= op_info.size;
					rec.illegal <= op_info.illegal;
					rec.operand_lo <= '0;
					rec.operand_hi <= '0;
				end
				decode_pkg::st_lo: rec.operand_lo <= in_byte.data;
				decode_pkg::st_hi: rec.operand_hi <= in_byte.data;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/credit_gate.sv */
`timescale 1ns/10ps
`default_nettype none

module credit_gate (
	input  wire logic                       clk,
	input  wire logic                       rst_n,
	input  wire logic                       rec_valid,
	input  wire decode_pkg::decoded_instr_t rec,
	output logic                            rec_take,
	input  wire logic                       credit_return,
	output logic                            out_valid,
	output decode_pkg::decoded_instr_t      out_instr
);

	logic [decode_pkg::credit_w-1:0] credit_cnt;

	assign rec_take = rec_valid && (credit_cnt != '0);

	// take and return together cancel out
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			credit_cnt <= decode_pkg::decode_credits[decode_pkg::credit_w-1:0];
		end else begin
			case ({rec_take, credit_return})
				2'b10: credit_cnt <= credit_cnt - 1'b1;
				2'b01: credit_cnt <= credit_cnt + 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= rec_take;
		end
	end

	always_ff @(posedge clk) begin
		if (rec_take) begin
			out_instr <= rec;
		end
	end

endmodule

`default_nettype wire

/* src/decode_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
	input  wire logic                     clk,
	input  wire logic                     rst_n,
	input  wire logic                     in_valid,
	input  wire decode_pkg::fetch_byte_t  in_byte,
	output logic                          in_ready,
	output logic                          out_valid,
	output decode_pkg::decoded_instr_t    out_instr,
	input  wire logic                     credit_return
);

	// collector to gate handoff
	logic rec_valid;
	logic rec_take;
	decode_pkg::decoded_instr_t rec;

	operand_collector i_operand_collector (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_byte   (in_byte),
		.in_ready  (in_ready),
		.rec_valid (rec_valid),
		.rec       (rec),
		.rec_take  (rec_take)
	);

	credit_gate i_credit_gate (
		.clk           (clk),
		.rst_n         (rst_n),
		.rec_valid     (rec_valid),
		.rec           (rec),
		.rec_take      (rec_take),
		.credit_return (credit_return),
		.out_valid     (out_valid),
		.out_instr     (out_instr)
	);

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
	output logic clk,
	output logic rst_n
);

	localparam int period_ns = 4;
	localparam int reset_cycles = 10;

	initial begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

/* dv/decode_stage_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_stage_sva (
	input wire logic                    clk,
	input wire logic                    rst_n,
	input wire logic                    in_valid,
	input wire decode_pkg::fetch_byte_t in_byte,
	input wire logic                    in_ready,
	input wire logic                    out_valid,
	input wire logic                    credit_return
);

	// records seen on the output minus credits handed back
	logic [decode_pkg::credit_w:0] out_cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_cnt <= '0;
		end else begin
			case ({out_valid, credit_return})
				2'b10: out_cnt <= out_cnt + 1'b1;
				2'b01: out_cnt <= out_cnt - 1'b1;
				default: ;
			endcase
		end
	end

	in_byte_stable: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid && !in_ready |=> $stable(in_byte))
		else $error("in_byte changed while fetch was stalled");

	credit_limit: assert property (@(posedge clk) disable iff (!rst_n)
		out_cnt <= decode_pkg::decode_credits)
		else $error("more records outstanding than credits");

	// every record needs a free slot in the execute stage
	free_slot: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> out_cnt < decode_pkg::decode_credits)
		else $error("record sent without a free credit");

endmodule

bind decode_stage decode_stage_sva i_decode_stage_sva (
	.clk           (clk),
	.rst_n         (rst_n),
	.in_valid      (in_valid),
	.in_byte       (in_byte),
	.in_ready      (in_ready),
	.out_valid     (out_valid),
	.credit_return (credit_return)
);

`default_nettype wire

/* dv/tb_decode_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_decode_stage;

	localparam int mem_words = 512;
	localparam int rec_words = 6;
	localparam int start_hold_cycles = 40;

	logic clk;
	logic rst_n;
	logic in_valid;
	decode_pkg::fetch_byte_t in_byte;
	logic in_ready;
	logic out_valid;
	decode_pkg::decoded_instr_t out_instr;
	logic credit_return;

	logic [15:0] stim_mem [mem_words];
	int n_bytes;
	int n_recs;
	int rec_base;
	int cycle_limit;
	int cycle_cnt;
	int err_cnt;
	int rx_count;
	int outstanding;
	int return_delay;
	int hold_cycles;
	bit start_hold;

	tb_clk_gen i_clk_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	decode_stage i_dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.in_valid      (in_valid),
		.in_byte       (in_byte),
		.in_ready      (in_ready),
		.out_valid     (out_valid),
		.out_instr     (out_instr),
		.credit_return (credit_return)
	);

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	// mostly short, now and then a long stretch with no credit
	function automatic int next_return_delay();
		int r;
		r = $urandom % 16;
		if (r == 0) begin
			return 30 + $urandom % 50;
		end
		return r % 4;
	endfunction

	task automatic check_field(input string name, input int idx, input logic [15:0] got,
			input logic [15:0] exp);
		if (got !== exp) begin
			$display("Error: %s of record %0d is 0x%h, expected 0x%h", name, idx, got, exp);
			err_cnt++;
		end
	endtask

	task automatic send_byte(input logic [7:0] data, input logic [15:0] pc);
		int gap;
		gap = $urandom % 3;
		repeat (gap) begin
			in_valid <= 1'b0;
			@(posedge clk);
		end
		in_valid <= 1'b1;
		in_byte.data <= data;
		in_byte.pc <= pc;
		@(posedge clk);
		while (!in_ready) begin
			@(posedge clk);
		end
	endtask

	task automatic report_and_finish(input bit timed_out);
		$display("errors: %0d, records: %0d of %0d", err_cnt, rx_count, n_recs);
		if (err_cnt == 0 && !timed_out) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	endtask

	//////////////////////////////////////////////////////////////////////
	// fetch driver
	//////////////////////////////////////////////////////////////////////

	initial begin : stimulus
		int pc;
		void'($urandom(32'h4f11_b962));
		in_valid <= 1'b0;
		in_byte <= '0;
		credit_return <= 1'b0;
		start_hold = 1'b1;
		$readmemh("dv/decode_testdata.txt", stim_mem);
		pc = stim_mem[0];
		n_bytes = stim_mem[1];
		n_recs = stim_mem[2];
		rec_base = 3 + n_bytes;
		cycle_limit = 40 * n_bytes + 100;
		wait (rst_n === 1'b1);
		@(posedge clk);
		if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
			$display("Error: after reset out_valid 0x%h in_ready 0x%h, expected 0x0 0x1",
				out_valid, in_ready);
			err_cnt++;
		end
		for (int i = 0; i < n_bytes; i++) begin
			send_byte(stim_mem[3 + i][7:0], 16'(pc + i));
		end
		in_valid <= 1'b0;
		while (rx_count < n_recs) begin
			@(posedge clk);
		end
		// catch any record beyond the last one
		repeat (20) @(posedge clk);
		report_and_finish(1'b0);
	end

	//////////////////////////////////////////////////////////////////////
	// execute side checker and credit return
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin : consume_check
		int b;
		if (rst_n) begin
			credit_return <= 1'b0;
			if (out_valid) begin
				if (rx_count < n_recs) begin
					b = rec_base + rec_words * rx_count;
					check_field("out_instr.pc", rx_count, out_instr.pc, stim_mem[b]);
					check_field("out_instr.mode", rx_count, {12'h0, out_instr.mode},
						stim_mem[b + 1]);
					check_field("out_instr.size", rx_count, {14'h0, out_instr.size},
						stim_mem[b + 2]);
					check_field("out_instr.illegal", rx_count, {15'h0, out_instr.illegal},
						stim_mem[b + 3]);
					check_field("out_instr.operand_lo", rx_count, {8'h0, out_instr.operand_lo},
						stim_mem[b + 4]);
					check_field("out_instr.operand_hi", rx_count, {8'h0, out_instr.operand_hi},
						stim_mem[b + 5]);
				end else begin
					$display("extra record with pc 0x%h after the last expected one",
						out_instr.pc);
					err_cnt++;
				end
				rx_count++;
				outstanding++;
			end
			if (outstanding > decode_pkg::decode_credits) begin
				$display("Error: outstanding records 0x%h exceed the limit 0x%h",
					outstanding, decode_pkg::decode_credits);
				err_cnt++;
			end
			// no credit back until the first window is full and quiet
			if (start_hold) begin
				if (rx_count >= decode_pkg::decode_credits) begin
					hold_cycles++;
				end
				if (hold_cycles == start_hold_cycles) begin
					start_hold = 1'b0;
					if (rx_count != decode_pkg::decode_credits) begin
						$display("Error: records before first credit is 0x%h, expected 0x%h",
							rx_count, decode_pkg::decode_credits);
						err_cnt++;
					end
				end
			end else if (return_delay > 0) begin
				return_delay--;
			end else if (outstanding > 0) begin
				credit_return <= 1'b1;
				outstanding--;
				return_delay = next_return_delay();
			end
		end
	end

	initial begin : watchdog
		wait (cycle_limit > 0);
		while (cycle_cnt < cycle_limit) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout after %0d cycles with %0d of %0d records received",
			cycle_cnt, rx_count, n_recs);
		report_and_finish(1'b1);
	end

endmodule

`default_nettype wire

/* dv/decode_testdata.txt */
// header: start pc, stream byte count, record count
// then the stream bytes, then one record per line: pc mode size illegal operand_lo operand_hi
0200 0029 0016
ea 0a a9 44 a5 10 f0 fe
8d 34 12 bd 00 30 02 b9 78 56
ff 18 4c 00 c0 95 20 a2 05 60
6c 00 02 80 b6 30 20 10 20
6a 91 40 e8
// mode 0 none 1 accum 2 imm 3 abs 4 zp 5 zpx 6 absx 7 impl 8 rel a indy b ind c zpy d absy
0200 7 1 0 00 00
0201 1 1 0 00 00
0202 2 2 0 44 00
0204 4 2 0 10 00
0206 8 2 0 fe 00
0208 3 3 0 34 12
020b 6 3 0 00 30
020e 0 1 1 00 00
020f d 3 0 78 56
0212 0 1 1 00 00
0213 7 1 0 00 00
0214 3 3 0 00 c0
0217 5 2 0 20 00
0219 2 2 0 05 00
021b 7 1 0 00 00
021c b 3 0 00 02
021f 0 1 1 00 00
0220 c 2 0 30 00
0222 3 3 0 10 20
0225 1 1 0 00 00
0226 a 2 0 40 00
0228 7 1 0 00 00

/* sources.f */
src/decode_pkg.sv
src/opcode_table.sv
src/operand_collector.sv
src/credit_gate.sv
src/decode_stage.sv
dv/tb_clk_gen.sv
dv/decode_stage_sva.sv
dv/tb_decode_stage.sv

/* Bender.yml */
package:
  name: decode_stage

sources:
  - files:
      - src/decode_pkg.sv
      - src/opcode_table.sv
      - src/operand_collector.sv
      - src/credit_gate.sv
      - src/decode_stage.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/decode_stage_sva.sv
      - dv/tb_decode_stage.sv
